// ==== common/cgu_pkg.sv ====
// clock gating unit definitions
package cgu_pkg;

  // --------------------
  // agent ism encoding, as driven on ism_out
  typedef enum logic [2:0]
  {
    AGT_IDLE        = 3'b000,
    AGT_ACTIVE_REQ  = 3'b001,
    AGT_IDLE_REQ    = 3'b010,
    AGT_ACTIVE      = 3'b011,
    AGT_CREDIT_REQ  = 3'b100,
    AGT_CREDIT_INIT = 3'b101,
    AGT_CREDIT_DONE = 3'b110   // 3'b111 unused
  } agent_state_e;

  // --------------------
  // fabric ism encoding, as seen on ism_in
  typedef enum logic [2:0]
  {
    FAB_IDLE        = 3'b000,
    FAB_ACTIVE_REQ  = 3'b001,
    FAB_IDLE_NAK    = 3'b010,  // fabric refuses the idle request
    FAB_ACTIVE      = 3'b011,
    FAB_CREDIT_REQ  = 3'b100,  // fabric asks for credit reinit
    FAB_CREDIT_INIT = 3'b101,
    FAB_CREDIT_ACK  = 3'b110
  } fabric_state_e;

  // --------------------
  // one-hot view of the agent state register
  typedef struct packed
  {
    logic active;
    logic activereq;
    logic idle;
    logic idlereq;
    logic creditreq;
    logic creditinit;
    logic creditdone;
  } ism_status_t;

  // default width of the idle counter and of cfg_idlecnt
  localparam int unsigned IDLE_CNT_W_DEF = 8;

endpackage

// ==== ism/agent_ism.sv ====
// agent idle state machine
`timescale 1ns/1ns

module agent_ism
(
  input  logic                   clk,
  input  logic                   rst_b,
  input  logic                   side_clk_valid,   // sideband clock is running
  input  logic                   int_pok,          // agent is powered
  input  logic                   force_creditreq,  // local request for credit reinit
  input  logic                   idle,             // idle limit reached
  input  logic                   ip_wake,          // agent has work
  input  logic                   init_done,        // credit init finished
  input  cgu_pkg::fabric_state_e ism_in,
  output cgu_pkg::agent_state_e  ism_out,
  output cgu_pkg::ism_status_t   ism_status,
  output logic                   credit_reinit     // one cycle on fabric forced reinit
);

  cgu_pkg::agent_state_e state_d;
  logic                  init_pend;    // credit init still owed since reset
  logic                  init_pend_d;
  logic                  reinit_d;

  // --------------------
  // next state, every arc waits for the other side's state
  always_comb
  begin
    state_d     = ism_out;   // hold by default, fabric back-pressure
    init_pend_d = init_pend;
    reinit_d    = 1'b0;
    case (ism_out)
      cgu_pkg::AGT_IDLE:
      begin
        if (init_pend)
        begin
          // first credit request once clock and power are good
          if (side_clk_valid & int_pok)
          begin
            state_d     = cgu_pkg::AGT_CREDIT_REQ;
            init_pend_d = 1'b0;
          end
        end
        else if (ism_in == cgu_pkg::FAB_CREDIT_REQ)
        begin
          state_d  = cgu_pkg::AGT_CREDIT_REQ;
          reinit_d = 1'b1;                          // fabric forced entry
        end
        else if (force_creditreq)
          state_d = cgu_pkg::AGT_CREDIT_REQ;        // local reinit, no credit_reinit
        else if (ip_wake | (ism_in == cgu_pkg::FAB_ACTIVE_REQ))
          state_d = cgu_pkg::AGT_ACTIVE_REQ;
      end
      cgu_pkg::AGT_ACTIVE_REQ:
        if (ism_in == cgu_pkg::FAB_ACTIVE)
          state_d = cgu_pkg::AGT_ACTIVE;
      cgu_pkg::AGT_ACTIVE:
        if (idle)
          state_d = cgu_pkg::AGT_IDLE_REQ;
      cgu_pkg::AGT_IDLE_REQ:
      begin
        if (ism_in == cgu_pkg::FAB_IDLE)
          state_d = cgu_pkg::AGT_IDLE;
        else if (ism_in == cgu_pkg::FAB_IDLE_NAK)
          state_d = cgu_pkg::AGT_ACTIVE;            // idle refused, back to work
      end
      cgu_pkg::AGT_CREDIT_REQ:
        if (ism_in == cgu_pkg::FAB_CREDIT_ACK)
          state_d = cgu_pkg::AGT_CREDIT_INIT;
      cgu_pkg::AGT_CREDIT_INIT:
        if (init_done)
          state_d = cgu_pkg::AGT_CREDIT_DONE;
      cgu_pkg::AGT_CREDIT_DONE:
        if (ism_in == cgu_pkg::FAB_IDLE)
          state_d = cgu_pkg::AGT_IDLE;
      default:
        state_d = cgu_pkg::AGT_IDLE;                // unused code, recover
    endcase
  end

  // --------------------
  // state, pending init and reinit flops
  always_ff @(posedge clk or negedge rst_b)
  begin
    if (~rst_b)
    begin
      ism_out       <= cgu_pkg::AGT_IDLE;
      init_pend     <= 1'b1;   // reset always owes a credit init
      credit_reinit <= 1'b0;
    end
    else
    begin
      ism_out       <= state_d;
      init_pend     <= init_pend_d;
      credit_reinit <= reinit_d;   // high for the first CREDIT_REQ cycle only
    end
  end

  // status flags straight off the state register
  always_comb
  begin
    ism_status            = '0;
    ism_status.active     = (ism_out == cgu_pkg::AGT_ACTIVE);
    ism_status.activereq  = (ism_out == cgu_pkg::AGT_ACTIVE_REQ);
    ism_status.idle       = (ism_out == cgu_pkg::AGT_IDLE);
    ism_status.idlereq    = (ism_out == cgu_pkg::AGT_IDLE_REQ);
    ism_status.creditreq  = (ism_out == cgu_pkg::AGT_CREDIT_REQ);
    ism_status.creditinit = (ism_out == cgu_pkg::AGT_CREDIT_INIT);
    ism_status.creditdone = (ism_out == cgu_pkg::AGT_CREDIT_DONE);
  end

endmodule

// ==== ism/credit_init_seq.sv ====
// credit initialization sequencer
`timescale 1ns/1ns

module credit_init_seq
(
  input  logic                   clk,
  input  logic                   rst_b,
  input  cgu_pkg::fabric_state_e ism_in,
  input  cgu_pkg::ism_status_t   ism_status,
  input  logic                   credit_init_done,  // pulse from the credit counters
  output logic                   credit_init,       // credit exchange may run
  output logic                   init_done          // lets the agent ism leave CREDIT_INIT
);

  typedef enum logic [1:0]
  {
    SEQ_IDLE = 2'b00,
    SEQ_HOLD = 2'b01,   // credit_init held high
    SEQ_DONE = 2'b10    // waiting for fabric idle
  } seq_state_e;

  seq_state_e seq_q;

  // --------------------
  // sequencer
  always_ff @(posedge clk or negedge rst_b)
  begin
    if (~rst_b)
      seq_q <= SEQ_IDLE;
    else
    begin
      case (seq_q)
        SEQ_IDLE:
          // agent asks, fabric acks, same edge as agent enters CREDIT_INIT
          if (ism_status.creditreq & (ism_in == cgu_pkg::FAB_CREDIT_ACK))
            seq_q <= SEQ_HOLD;
        SEQ_HOLD:
          if (credit_init_done)
            seq_q <= SEQ_DONE;
        SEQ_DONE:
          if (ism_in == cgu_pkg::FAB_IDLE)
            seq_q <= SEQ_IDLE;
        default:
          seq_q <= SEQ_IDLE;
      endcase
    end
  end

  // tracks agent CREDIT_INIT cycle for cycle
  assign credit_init = (seq_q == SEQ_HOLD);

  // the pulse itself or the sticky done state
  assign init_done = credit_init_done | (seq_q == SEQ_DONE);

endmodule

// ==== logic/idle_gate_ctrl.sv ====
// idle counter and clock gating terms
`timescale 1ns/1ns

module idle_gate_ctrl
#(
  parameter int unsigned IDLE_CNT_W = 8
)
(
  input  logic                   clk,
  input  logic                   rst_b,
  input  logic                   cfg_clkgaten,   // clock gating enable
  input  logic [IDLE_CNT_W-1:0]  cfg_idlecnt,    // idle limit in cycles
  input  logic                   count_idle,     // agent has nothing queued
  input  logic                   ip_idle,        // agent allows its clock to stop
  input  logic                   int_pok,
  input  cgu_pkg::fabric_state_e ism_in,
  input  cgu_pkg::ism_status_t   ism_status,
  input  logic                   credit_reinit,
  output logic                   maxidlecnt,     // idle limit reached
  output logic                   idle,           // to the agent ism, request idle
  output logic                   ip_wake,        // to the agent ism, leave idle
  output logic                   cg_inprogress,  // local clock may be gated
  output logic                   ism_idle        // both ism sides idle
);

  logic [IDLE_CNT_W-1:0] idle_cnt;
  logic                  cnt_clr;

  // --------------------
  // idle counter
  // counting needs both sides ACTIVE with gating enabled
  assign cnt_clr = ~count_idle |
                   ~ism_status.active |
                   (ism_in != cgu_pkg::FAB_ACTIVE) |
                   ~cfg_clkgaten;

  always_ff @(posedge clk or negedge rst_b)
  begin
    if (~rst_b)
      idle_cnt <= '0;
    else if (cnt_clr)
    begin
      if (idle_cnt != '0)              // only write on a real change
        idle_cnt <= '0;
    end
    else if (~maxidlecnt)
      idle_cnt <= idle_cnt + 1'b1;     // stops at the limit
  end

  assign maxidlecnt = (idle_cnt >= cfg_idlecnt) & cfg_clkgaten;

  // --------------------
  // ism request terms
  assign idle    = count_idle & maxidlecnt & cfg_clkgaten;
  assign ip_wake = ~ip_idle;

  // powered up, the ism decides; powered down, ip_idle alone so the port
  // can still wake up and reject messages
  assign cg_inprogress = (ism_status.idle & ip_idle & int_pok) |
                         (ip_idle & ~int_pok);

  // a reinit holds the port out of idle unless power is off
  assign ism_idle = ism_status.idle &
                    (ism_in == cgu_pkg::FAB_IDLE) &
                    (~credit_reinit | ~int_pok);

endmodule

// ==== logic/sb_cgu.sv ====
// sideband clock gating unit
`timescale 1ns/1ns

module sb_cgu
#(
  parameter int unsigned IDLE_CNT_W = cgu_pkg::IDLE_CNT_W_DEF
)
(
  input  logic                   clk,
  input  logic                   rst_b,
  input  logic                   force_creditreq,
  input  logic                   cfg_clkgaten,
  input  logic [IDLE_CNT_W-1:0]  cfg_idlecnt,
  input  logic                   side_clk_valid,
  input  cgu_pkg::fabric_state_e ism_in,
  input  logic                   ip_idle,
  input  logic                   count_idle,
  input  logic                   credit_init_done,
  input  logic                   int_pok,
  output cgu_pkg::agent_state_e  ism_out,
  output logic                   maxidlecnt,
  output logic                   cg_inprogress,
  output logic                   ism_idle,
  output logic                   credit_init,
  output logic                   credit_reinit,
  output cgu_pkg::ism_status_t   ism_status
);

  logic idle;        // idle limit hit, ask fabric for idle
  logic ip_wake;     // agent wants the link back
  logic init_done;   // credit init finished

  // --------------------
  // agent ism
  agent_ism u_agent_ism
  (
    .clk             (clk),
    .rst_b           (rst_b),
    .side_clk_valid  (side_clk_valid),
    .int_pok         (int_pok),
    .force_creditreq (force_creditreq),
    .idle            (idle),
    .ip_wake         (ip_wake),
    .init_done       (init_done),
    .ism_in          (ism_in),
    .ism_out         (ism_out),
    .ism_status      (ism_status),
    .credit_reinit   (credit_reinit)
  );

  // --------------------
  // credit init handshake
  credit_init_seq u_credit_init_seq
  (
    .clk              (clk),
    .rst_b            (rst_b),
    .ism_in           (ism_in),
    .ism_status       (ism_status),
    .credit_init_done (credit_init_done),
    .credit_init      (credit_init),
    .init_done        (init_done)
  );

  // --------------------
  // idle counting and gating indicators
  idle_gate_ctrl #(
    .IDLE_CNT_W (IDLE_CNT_W)
  ) u_idle_gate_ctrl
  (
    .clk           (clk),
    .rst_b         (rst_b),
    .cfg_clkgaten  (cfg_clkgaten),
    .cfg_idlecnt   (cfg_idlecnt),
    .count_idle    (count_idle),
    .ip_idle       (ip_idle),
    .int_pok       (int_pok),
    .ism_in        (ism_in),
    .ism_status    (ism_status),
    .credit_reinit (credit_reinit),
    .maxidlecnt    (maxidlecnt),
    .idle          (idle),
    .ip_wake       (ip_wake),
    .cg_inprogress (cg_inprogress),
    .ism_idle      (ism_idle)
  );

endmodule

// ==== dv/clk_rst_gen.sv ====
// testbench clock and reset
`timescale 1ns/1ns

module clk_rst_gen
#(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 10
)
(
  output logic clk,
  output logic rst_b
);

  initial
  begin
    clk   = 1'b0;
    rst_b = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst_b = 1'b1;   // released off the edge, like every other input
  end

  always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== dv/fabric_ism_model.sv ====
// behavioral fabric ISM
`timescale 1ns/1ns

module fabric_ism_model
(
  input  logic                   clk,
  input  logic                   rst_b,
  input  cgu_pkg::agent_state_e  ism_out,
  input  logic                   nak_req,   // refuse the next idle request
  input  logic                   creq_req,  // ask the agent for a credit reinit
  output cgu_pkg::fabric_state_e ism_in
);

  cgu_pkg::fabric_state_e nxt;

  // looks at the agent state at each edge, answers 1 ns later
  initial
  begin
    ism_in = cgu_pkg::FAB_IDLE;
    forever
    begin
      @(posedge clk);
      nxt = cgu_pkg::FAB_IDLE;
      if (rst_b)
        case (ism_out)
          cgu_pkg::AGT_IDLE:
            if (creq_req | (ism_in == cgu_pkg::FAB_CREDIT_REQ))
              nxt = cgu_pkg::FAB_CREDIT_REQ;   // held until the agent follows
          cgu_pkg::AGT_ACTIVE_REQ,
          cgu_pkg::AGT_ACTIVE:      nxt = cgu_pkg::FAB_ACTIVE;
          cgu_pkg::AGT_IDLE_REQ:
            nxt = nak_req ? cgu_pkg::FAB_IDLE_NAK : cgu_pkg::FAB_IDLE;
          cgu_pkg::AGT_CREDIT_REQ:  nxt = cgu_pkg::FAB_CREDIT_ACK;
          cgu_pkg::AGT_CREDIT_INIT: nxt = cgu_pkg::FAB_CREDIT_INIT;
          default:                  nxt = cgu_pkg::FAB_IDLE;   // CREDIT_DONE
        endcase
      #1 ism_in = nxt;
    end
  end

endmodule

// ==== dv/tb_sb_cgu.sv ====
// clock gating unit testbench
`timescale 1ns/1ns

module tb_sb_cgu;

  localparam int W        = cgu_pkg::IDLE_CNT_W_DEF;
  localparam int WAIT_MAX = 64;                          // cycles per state wait
  localparam int TEST_NS  = (10 + 12 * WAIT_MAX + 100) * 10;

  logic clk, rst_b;
  logic force_creditreq, cfg_clkgaten, side_clk_valid, ip_idle, count_idle;
  logic credit_init_done, int_pok;
  logic nak_req, creq_req;                               // fabric model controls
  logic [W-1:0] cfg_idlecnt;
  cgu_pkg::fabric_state_e ism_in;
  cgu_pkg::agent_state_e  ism_out;
  cgu_pkg::ism_status_t   ism_status;
  logic maxidlecnt, cg_inprogress, ism_idle, credit_init, credit_reinit;
  logic exp_cg, exp_ism_idle;
  integer seed = 32'hbb4b6985;
  int value_errs = 0;
  int other_errs = 0;

  clk_rst_gen u_clk_rst (.*);
  fabric_ism_model u_fabric (.*);
  sb_cgu #(.IDLE_CNT_W (W)) dut0 (.*);

  // gating indicators by rule
  assign exp_cg = ip_idle & (~int_pok | (ism_out == cgu_pkg::AGT_IDLE));
  assign exp_ism_idle = (ism_out == cgu_pkg::AGT_IDLE) && (ism_in == cgu_pkg::FAB_IDLE) &&
                        !(credit_reinit && int_pok);

  // one status flag per agent state, in struct order
  function automatic logic [6:0] status_for_state(input cgu_pkg::agent_state_e s);
    case (s)
      cgu_pkg::AGT_ACTIVE:      return 7'b1000000;
      cgu_pkg::AGT_ACTIVE_REQ:  return 7'b0100000;
      cgu_pkg::AGT_IDLE:        return 7'b0010000;
      cgu_pkg::AGT_IDLE_REQ:    return 7'b0001000;
      cgu_pkg::AGT_CREDIT_REQ:  return 7'b0000100;
      cgu_pkg::AGT_CREDIT_INIT: return 7'b0000010;
      cgu_pkg::AGT_CREDIT_DONE: return 7'b0000001;
      default:                  return 7'b0000000;
    endcase
  endfunction

  task automatic log_mismatch(input string test, input int exp, input int act);
    value_errs++;
    $display("Fail %s exp=%0d act=%0d", test, exp, act);
  endtask

  task automatic next_cycle(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic wait_state(input cgu_pkg::agent_state_e s);
    int n = 0;
    while ((ism_out != s) && (n < WAIT_MAX))
    begin
      next_cycle(1);
      n++;
    end
    if (ism_out != s)
    begin
      other_errs++;
      $display("agent ISM did not reach %s within %0d cycles", s.name(), WAIT_MAX);
    end
  endtask

  // credit init, random latency to the done pulse
  task automatic complete_credit_init();
    wait_state(cgu_pkg::AGT_CREDIT_INIT);
    next_cycle(1 + ($unsigned($random(seed)) % 8));
    credit_init_done = 1'b1;
    next_cycle(1);
    credit_init_done = 1'b0;
    wait_state(cgu_pkg::AGT_IDLE);
  endtask

  // gating off first, then count to a random limit
  task automatic enter_idle(input logic nak);
    cfg_idlecnt  = W'(1 + ($unsigned($random(seed)) % 15));
    nak_req      = nak;
    count_idle   = 1'b1;
    cfg_clkgaten = 1'b0;
    next_cycle(4 + ($unsigned($random(seed)) % 8));
    cfg_clkgaten = 1'b1;
    wait_state(cgu_pkg::AGT_IDLE_REQ);
    count_idle   = 1'b0;
    wait_state(nak ? cgu_pkg::AGT_ACTIVE : cgu_pkg::AGT_IDLE);
  endtask

  // --------------------
  // checks
  a_cinit: assert property (@(posedge clk) disable iff (!rst_b)
      credit_init == (ism_out == cgu_pkg::AGT_CREDIT_INIT))
    else log_mismatch("credit_init", $sampled(ism_out == cgu_pkg::AGT_CREDIT_INIT),
                      $sampled(credit_init));
  a_done: assert property (@(posedge clk) disable iff (!rst_b)
      ism_out == cgu_pkg::AGT_CREDIT_INIT && credit_init_done
      |=> ism_out == cgu_pkg::AGT_CREDIT_DONE)
    else log_mismatch("credit_done", cgu_pkg::AGT_CREDIT_DONE, $sampled(ism_out));
  a_wake: assert property (@(posedge clk) disable iff (!rst_b)
      ism_out == cgu_pkg::AGT_IDLE && ism_in == cgu_pkg::FAB_IDLE && !ip_idle && !force_creditreq
      |=> ism_out == cgu_pkg::AGT_ACTIVE_REQ)
    else log_mismatch("wake", cgu_pkg::AGT_ACTIVE_REQ, $sampled(ism_out));
  a_active: assert property (@(posedge clk) disable iff (!rst_b)
      ism_out == cgu_pkg::AGT_ACTIVE_REQ && ism_in == cgu_pkg::FAB_ACTIVE
      |=> ism_out == cgu_pkg::AGT_ACTIVE)
    else log_mismatch("active", cgu_pkg::AGT_ACTIVE, $sampled(ism_out));
  a_maxgate: assert property (@(posedge clk) disable iff (!rst_b) !cfg_clkgaten |-> !maxidlecnt)
    else log_mismatch("maxidlecnt_gated", 0, $sampled(maxidlecnt));
  a_cause: assert property (@(posedge clk) disable iff (!rst_b)
      $rose(ism_out == cgu_pkg::AGT_IDLE_REQ) |-> $past(maxidlecnt && count_idle && cfg_clkgaten))
    else log_mismatch("idle_req_cause", 1, 0);
  a_gateoff: assert property (@(posedge clk) disable iff (!rst_b)
      ism_out == cgu_pkg::AGT_ACTIVE && !cfg_clkgaten |=> ism_out == cgu_pkg::AGT_ACTIVE)
    else log_mismatch("gating_off", cgu_pkg::AGT_ACTIVE, $sampled(ism_out));
  a_nak: assert property (@(posedge clk) disable iff (!rst_b)
      ism_out == cgu_pkg::AGT_IDLE_REQ && ism_in == cgu_pkg::FAB_IDLE_NAK
      |=> ism_out == cgu_pkg::AGT_ACTIVE)
    else log_mismatch("idle_nak", cgu_pkg::AGT_ACTIVE, $sampled(ism_out));
  a_idle: assert property (@(posedge clk) disable iff (!rst_b)
      ism_out == cgu_pkg::AGT_IDLE_REQ && ism_in == cgu_pkg::FAB_IDLE
      |=> ism_out == cgu_pkg::AGT_IDLE)
    else log_mismatch("idle_ack", cgu_pkg::AGT_IDLE, $sampled(ism_out));
  a_cg: assert property (@(posedge clk) disable iff (!rst_b) cg_inprogress == exp_cg)
    else log_mismatch("cg_inprogress", $sampled(exp_cg), $sampled(cg_inprogress));
  a_ismidle: assert property (@(posedge clk) disable iff (!rst_b) ism_idle == exp_ism_idle)
    else log_mismatch("ism_idle", $sampled(exp_ism_idle), $sampled(ism_idle));
  a_status: assert property (@(posedge clk) disable iff (!rst_b)
      ism_status == status_for_state(ism_out))
    else log_mismatch("ism_status", status_for_state($sampled(ism_out)), $sampled(ism_status));
  a_reinit: assert property (@(posedge clk) disable iff (!rst_b)
      ism_out == cgu_pkg::AGT_IDLE && ism_in == cgu_pkg::FAB_CREDIT_REQ |=> credit_reinit)
    else log_mismatch("credit_reinit", 1, $sampled(credit_reinit));
  a_pulse: assert property (@(posedge clk) disable iff (!rst_b) credit_reinit |=> !credit_reinit)
    else log_mismatch("credit_reinit_pulse", 0, $sampled(credit_reinit));
  a_force: assert property (@(posedge clk) disable iff (!rst_b)
      ism_out == cgu_pkg::AGT_IDLE && ism_in == cgu_pkg::FAB_IDLE && force_creditreq && ip_idle
      |=> ism_out == cgu_pkg::AGT_CREDIT_REQ && !credit_reinit)
    else log_mismatch("force_creditreq", cgu_pkg::AGT_CREDIT_REQ, $sampled(ism_out));

  // --------------------
  // stimulus
  initial
  begin
    force_creditreq  = 1'b0;
    cfg_clkgaten     = 1'b0;
    cfg_idlecnt      = '0;
    side_clk_valid   = 1'b0;   // clock not valid yet
    ip_idle          = 1'b1;
    count_idle       = 1'b0;
    credit_init_done = 1'b0;
    int_pok          = 1'b1;
    nak_req          = 1'b0;
    creq_req         = 1'b0;
    @(posedge rst_b);
    next_cycle(1 + ($unsigned($random(seed)) % 4));
    side_clk_valid = 1'b1;
    wait_state(cgu_pkg::AGT_CREDIT_REQ);   // boot credit request
    complete_credit_init();
    ip_idle = 1'b0;                        // agent has work
    wait_state(cgu_pkg::AGT_ACTIVE);
    ip_idle = 1'b1;
    enter_idle(1'b1);
    enter_idle(1'b0);
    repeat (12)                            // power toggles while idle
    begin
      int_pok = 1'($random(seed));
      next_cycle(1);
    end
    int_pok  = 1'b1;
    creq_req = 1'b1;                       // fabric forced reinit
    next_cycle(1);
    creq_req = 1'b0;
    complete_credit_init();
    force_creditreq = 1'b1;                // local reinit
    next_cycle(1);
    force_creditreq = 1'b0;
    complete_credit_init();
    next_cycle(4);
    $display("value errors %0d, other errors %0d", value_errs, other_errs);
    if ((value_errs + other_errs) == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(TEST_NS);
    $display("timeout, tests still running after %0d ns", TEST_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
common/cgu_pkg.sv
ism/agent_ism.sv
ism/credit_init_seq.sv
logic/idle_gate_ctrl.sv
logic/sb_cgu.sv
dv/clk_rst_gen.sv
dv/fabric_ism_model.sv
dv/tb_sb_cgu.sv

// ==== Bender.yml ====
package:
  name: sb_cgu

sources:
  - common/cgu_pkg.sv
  - ism/agent_ism.sv
  - ism/credit_init_seq.sv
  - logic/idle_gate_ctrl.sv
  - logic/sb_cgu.sv
  - target: test
    files:
      - dv/clk_rst_gen.sv
      - dv/fabric_ism_model.sv
      - dv/tb_sb_cgu.sv
